/* compile.f */
design/ooo_issue_pkg.sv
design/ooo_hazard_unit.sv
design/busy_scoreboard.sv
design/exec_unit.sv
design/completion_buffer.sv
design/ooo_issue_top.sv
dv/ooo_issue_asserts.sv
dv/ooo_issue_tb.sv

/* Bender.yml */
package:
  name: ooo_issue

sources:
  - design/ooo_issue_pkg.sv
  - design/ooo_hazard_unit.sv
  - design/busy_scoreboard.sv
  - design/exec_unit.sv
  - design/completion_buffer.sv
  - design/ooo_issue_top.sv
  - target: test
    files:
      - dv/ooo_issue_asserts.sv
      - dv/ooo_issue_tb.sv

/* dv/ooo_issue_tb.sv */
`timescale 1ns/1ps

module ooo_issue_tb import ooo_issue_pkg::*; ();

  // four units against four entries so that the buffer can run full
  localparam int num_units    = 4;
  localparam int rob_depth    = 4;
  localparam int exec_latency = 5;
  localparam int uw           = unit_idx_w(num_units);
  localparam int num_rows     = 24;
  localparam int seed         = 99;
  localparam int margin       = 4;
  localparam int max_cycles   = num_rows * (exec_latency + rob_depth + margin);

  // one instruction of the table with its expected result
  typedef struct packed {
    logic [uw-1:0]         unit;
    alu_op_t               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  use1;
    logic                  use2;
    logic                  wen;
    logic                  store;
    logic                  fault;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       a;
    logic [xlen-1:0]       b;
    logic [xlen-1:0]       exp;
  } row_t;

  logic                  clk;
  logic                  reset;
  logic                  in_valid;
  logic [uw-1:0]         in_unit;
  alu_op_t               in_op;
  logic [reg_addr_w-1:0] in_rd;
  logic [reg_addr_w-1:0] in_rs1;
  logic [reg_addr_w-1:0] in_rs2;
  logic                  in_use_rs1;
  logic                  in_use_rs2;
  logic                  in_wen;
  logic                  in_store;
  logic                  in_fault;
  logic [xlen-1:0]       in_pc;
  logic [xlen-1:0]       in_a;
  logic [xlen-1:0]       in_b;
  logic                  stall;
  logic                  commit_valid;
  logic [reg_addr_w-1:0] commit_rd;
  logic                  commit_wen;
  logic [xlen-1:0]       commit_data;
  logic                  exception;
  logic [xlen-1:0]       epc;

  row_t        rows [num_rows];
  int          n_rows;
  logic [31:0] lcg_state;
  // testbench view of what is in flight, oldest first
  int          inflight [$];
  int          exp_commits [$];
  int          exp_faults [$];
  // registers with a write still outstanding
  logic [31:0] pending;
  int          next_row;
  int          num_accepted;
  int          num_commits;
  int          num_exceptions;
  int          mismatches;
  int          other_errors;

  ooo_issue_top #(
    .num_units    (num_units),
    .rob_depth    (rob_depth),
    .exec_latency (exec_latency)
  ) i_ooo_issue_top (.*);

  bind ooo_issue_top ooo_issue_asserts #(
    .num_units (num_units)
  ) i_ooo_issue_asserts (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .exception    (exception),
    .commit_valid (commit_valid),
    .unit_busy    (unit_busy),
    .unit_start   (unit_start)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected result straight from the op rules
  function automatic logic [xlen-1:0] ref_result(input alu_op_t op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [xlen-1:0] v;
    case (op)
      op_add: v = a + b;
      // two's complement subtraction
      op_sub: v = a + ~b + 1'b1;
      op_xor: v = a ^ b;
      op_sll: begin
        // one doubling per step of the five-bit shift amount
        v = a;
        for (int i = 0; i < int'(b[4:0]); i++) begin
          v = v + v;
        end
      end
      default: v = 'x;
    endcase
    return v;
  endfunction

  task automatic add_row(input int unit, input alu_op_t op, input int rd, input int rs1,
                         input int rs2, input bit use1, input bit use2, input bit wen,
                         input bit store, input bit fault);
    row_t row;
    row.unit  = uw'(unit);
    row.op    = op;
    row.rd    = reg_addr_w'(rd);
    row.rs1   = reg_addr_w'(rs1);
    row.rs2   = reg_addr_w'(rs2);
    row.use1  = use1;
    row.use2  = use2;
    row.wen   = wen;
    row.store = store;
    row.fault = fault;
    row.pc    = 32'h0000_0100 + 32'(n_rows * 4);
    lcg_state = lcg_next(lcg_state);
    row.a     = lcg_state;
    lcg_state = lcg_next(lcg_state);
    row.b     = lcg_state;
    row.exp   = ref_result(op, row.a, row.b);
    rows[n_rows] = row;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    // unit, op, rd, rs1, rs2, use1, use2, wen, store, fault
    add_row(0, op_add,  1,  0,  0, 0, 0, 1, 0, 0);
    add_row(1, op_sub,  2,  0,  0, 0, 0, 1, 0, 0);
    add_row(2, op_xor,  3,  0,  0, 0, 0, 1, 0, 0);
    add_row(3, op_sll,  4,  0,  0, 0, 0, 1, 0, 0);
    // RAW on x1, then on x2 and x3
    add_row(0, op_add,  5,  1,  0, 1, 0, 1, 0, 0);
    add_row(1, op_sub,  6,  2,  3, 1, 1, 1, 0, 0);
    // WAW on x5
    add_row(2, op_xor,  5,  4,  0, 1, 0, 1, 0, 0);
    add_row(3, op_sll,  7,  0,  0, 0, 0, 1, 0, 0);
    add_row(0, op_add,  8,  6,  0, 1, 0, 0, 0, 0);
    // store has to wait for an empty buffer
    add_row(1, op_add,  0,  7,  5, 1, 1, 0, 1, 0);
    add_row(2, op_xor,  9,  0,  0, 0, 0, 1, 0, 0);
    add_row(3, op_sub, 10,  9,  0, 1, 0, 1, 0, 0);
    // fault with younger rows queued behind it
    add_row(0, op_add, 11,  0,  0, 0, 0, 1, 0, 1);
    add_row(1, op_add, 12,  0,  0, 0, 0, 1, 0, 0);
    add_row(2, op_sll, 13, 12,  0, 1, 0, 1, 0, 0);
    add_row(3, op_xor, 14,  0,  0, 0, 0, 1, 0, 0);
    add_row(0, op_sub, 15,  0, 14, 0, 1, 1, 0, 0);
    add_row(2, op_add,  0,  0,  0, 0, 0, 0, 1, 0);
    add_row(1, op_add, 16,  0,  0, 0, 0, 1, 0, 0);
    // two faults back to back
    add_row(3, op_xor,  0,  0,  0, 0, 0, 0, 0, 1);
    add_row(0, op_xor, 17,  0,  0, 0, 0, 1, 0, 1);
    add_row(2, op_sll, 18, 16,  4, 1, 1, 1, 0, 0);
    add_row(3, op_add, 19, 18,  0, 1, 0, 1, 0, 0);
    add_row(1, op_sub, 20,  0,  0, 0, 0, 1, 0, 0);
    // reference streams, retirement follows table order
    for (int r = 0; r < n_rows; r++) begin
      if (rows[r].fault) begin
        exp_faults.push_back(r);
      end else begin
        exp_commits.push_back(r);
      end
    end
  endtask

  task automatic idle_inputs();
    in_valid   = 1'b0;
    in_unit    = '0;
    in_op      = op_add;
    in_rd      = '0;
    in_rs1     = '0;
    in_rs2     = '0;
    in_use_rs1 = 1'b0;
    in_use_rs2 = 1'b0;
    in_wen     = 1'b0;
    in_store   = 1'b0;
    in_fault   = 1'b0;
    in_pc      = '0;
    in_a       = '0;
    in_b       = '0;
  endtask

  task automatic drive_row(input int r);
    in_valid   = 1'b1;
    in_unit    = rows[r].unit;
    in_op      = rows[r].op;
    in_rd      = rows[r].rd;
    in_rs1     = rows[r].rs1;
    in_rs2     = rows[r].rs2;
    in_use_rs1 = rows[r].use1;
    in_use_rs2 = rows[r].use2;
    in_wen     = rows[r].wen;
    in_store   = rows[r].store;
    in_fault   = rows[r].fault;
    in_pc      = rows[r].pc;
    in_a       = rows[r].a;
    in_b       = rows[r].b;
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    assert (actual === expected)
      else begin
        $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        mismatches++;
      end
  endtask

  // retirement seen this cycle takes effect at the next rising edge
  task automatic check_retirement();
    int r;
    int head;
    if (commit_valid) begin
      num_commits++;
      assert (exp_commits.size() > 0 && inflight.size() > 0)
        else begin
          $display("ERROR: commit seen with no accepted row waiting to retire");
          other_errors++;
        end
      if (exp_commits.size() > 0 && inflight.size() > 0) begin
        r    = exp_commits.pop_front();
        head = inflight.pop_front();
        check_value($sformatf("commit_order row %0d", r), r, head);
        check_value($sformatf("commit_rd row %0d", r), rows[r].rd, commit_rd);
        check_value($sformatf("commit_wen row %0d", r), rows[r].wen, commit_wen);
        check_value($sformatf("commit_data row %0d", r), rows[r].exp, commit_data);
        if (rows[head].wen) begin
          pending[rows[head].rd] = 1'b0;
        end
      end
    end
    if (exception) begin
      num_exceptions++;
      assert (exp_faults.size() > 0 && inflight.size() > 0)
        else begin
          $display("ERROR: exception seen with no faulting row waiting to retire");
          other_errors++;
        end
      if (exp_faults.size() > 0 && inflight.size() > 0) begin
        r    = exp_faults.pop_front();
        head = inflight[0];
        check_value($sformatf("exception_row row %0d", r), r, head);
        check_value($sformatf("epc row %0d", r), rows[r].pc, epc);
        // dispatch restarts right behind the faulting row
        next_row = r + 1;
      end
      // flush drops every younger row, they get replayed
      inflight.delete();
      pending = '0;
    end
  endtask

  // hazards that the DUT must have held back
  task automatic accept_row(input int r);
    if (rows[r].use1) begin
      assert (!pending[rows[r].rs1])
        else begin
          $display("ERROR: row %0d accepted while rs1 x%0d still pending", r, rows[r].rs1);
          other_errors++;
        end
    end
    if (rows[r].use2) begin
      assert (!pending[rows[r].rs2])
        else begin
          $display("ERROR: row %0d accepted while rs2 x%0d still pending", r, rows[r].rs2);
          other_errors++;
        end
    end
    if (rows[r].wen) begin
      assert (!pending[rows[r].rd])
        else begin
          $display("ERROR: row %0d accepted while rd x%0d still pending", r, rows[r].rd);
          other_errors++;
        end
    end
    if (rows[r].store) begin
      assert (inflight.size() == 0)
        else begin
          $display("ERROR: store row %0d accepted with %0d older rows in flight", r,
                   inflight.size());
          other_errors++;
        end
    end
    inflight.push_back(r);
    if (rows[r].wen && rows[r].rd != '0) begin
      pending[rows[r].rd] = 1'b1;
    end
    num_accepted++;
  endtask

  initial begin
    int cycles;
    clk            = 1'b0;
    reset          = 1'b1;
    lcg_state      = seed;
    pending        = '0;
    next_row       = 0;
    num_accepted   = 0;
    num_commits    = 0;
    num_exceptions = 0;
    mismatches     = 0;
    other_errors   = 0;
    cycles         = 0;
    idle_inputs();
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // one iteration per cycle, inputs change on the falling edge
    while ((num_commits + num_exceptions) < num_rows && cycles < max_cycles) begin
      check_retirement();
      if (next_row < num_rows) begin
        drive_row(next_row);
        // stall is settled and holds until the rising edge
        #1;
        if (!stall) begin
          accept_row(next_row);
          next_row++;
        end
      end else begin
        idle_inputs();
      end
      @(negedge clk);
      cycles++;
    end
    assert (num_commits + num_exceptions == num_rows)
      else begin
        $display("ERROR: timeout after %0d cycles with %0d of %0d rows retired", cycles,
                 num_commits + num_exceptions, num_rows);
        other_errors++;
      end
    // nothing may retire once the table is done
    idle_inputs();
    repeat (exec_latency + rob_depth) begin
      check_retirement();
      @(negedge clk);
    end
    assert (inflight.size() == 0 && exp_commits.size() == 0 && exp_faults.size() == 0)
      else begin
        $display("ERROR: rows left without retirement at the end of the run");
        other_errors++;
      end
    other_errors += i_ooo_issue_top.i_ooo_issue_asserts.failures;
    $display("summary: %0d mismatches, %0d other errors, %0d accepted, %0d commits, %0d %s",
             mismatches, other_errors, num_accepted, num_commits, num_exceptions,
             "exceptions");
    if (mismatches + other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* dv/ooo_issue_asserts.sv */
`timescale 1ns/1ps

module ooo_issue_asserts #(
  parameter int num_units = 1
) (
  input logic                 clk,
  input logic                 reset,
  input logic                 stall,
  input logic                 exception,
  input logic                 commit_valid,
  input logic [num_units-1:0] unit_busy,
  input logic [num_units-1:0] unit_start
);

  // failed checks, read back by the testbench
  int failures = 0;

  // first cycle out of reset starts quiet
  assert property (@(posedge clk) $fell(reset) |-> (!stall && !exception && !commit_valid))
    else begin
      $error("stall, exception or commit_valid high right after reset");
      failures++;
    end

  // flush empties the buffer, so the pulse cannot repeat
  assert property (@(posedge clk) disable iff (reset) exception |=> !exception)
    else begin
      $error("exception held for more than one cycle");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset) !(commit_valid && exception))
    else begin
      $error("commit_valid and exception high in the same cycle");
      failures++;
    end

  // units are not pipelined
  assert property (@(posedge clk) disable iff (reset) (unit_start & unit_busy) == '0)
    else begin
      $error("unit started while still busy");
      failures++;
    end

endmodule

/* design/ooo_issue_top.sv */
`timescale 1ns/1ps

module ooo_issue_top import ooo_issue_pkg::*; #(
  parameter int num_units    = default_num_units,
  parameter int rob_depth    = default_rob_depth,
  parameter int exec_latency = default_exec_latency
) (
  input  logic                             clk,
  input  logic                             reset,
  // decoded instruction, held while stall is high
  input  logic                             in_valid,
  input  logic [unit_idx_w(num_units)-1:0] in_unit,
  input  alu_op_t                          in_op,
  input  logic [reg_addr_w-1:0]            in_rd,
  input  logic [reg_addr_w-1:0]            in_rs1,
  input  logic [reg_addr_w-1:0]            in_rs2,
  input  logic                             in_use_rs1,
  input  logic                             in_use_rs2,
  input  logic                             in_wen,
  input  logic                             in_store,
  input  logic                             in_fault,
  input  logic [xlen-1:0]                  in_pc,
  input  logic [xlen-1:0]                  in_a,
  input  logic [xlen-1:0]                  in_b,
  output logic                             stall,
  // retirement
  output logic                             commit_valid,
  output logic [reg_addr_w-1:0]            commit_rd,
  output logic                             commit_wen,
  output logic [xlen-1:0]                  commit_data,
  output logic                             exception,
  output logic [xlen-1:0]                  epc
);

  localparam int tw = tag_w(rob_depth);

  logic                 issue;
  logic                 flush;
  logic                 rs1_busy;
  logic                 rs2_busy;
  logic                 rd_busy;
  logic                 rob_full;
  logic                 rob_empty;
  logic [tw-1:0]        alloc_tag;
  logic [num_units-1:0] unit_busy;
  logic [num_units-1:0] unit_start;
  logic [num_units-1:0] wb_valid;
  logic [tw-1:0]        wb_tag  [num_units];
  logic [xlen-1:0]      wb_data [num_units];

  ooo_hazard_unit #(
    .num_units (num_units)
  ) i_ooo_hazard_unit (
    .in_valid   (in_valid),
    .in_unit    (in_unit),
    .in_use_rs1 (in_use_rs1),
    .in_use_rs2 (in_use_rs2),
    .in_wen     (in_wen),
    .in_store   (in_store),
    .in_fault   (in_fault),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .rd_busy    (rd_busy),
    .unit_busy  (unit_busy),
    .rob_full   (rob_full),
    .rob_empty  (rob_empty),
    .flush      (flush),
    .stall      (stall),
    .issue      (issue),
    .unit_start (unit_start)
  );

  busy_scoreboard i_busy_scoreboard (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .in_rd        (in_rd),
    .in_wen       (in_wen),
    .in_rs1       (in_rs1),
    .in_rs2       (in_rs2),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .flush        (flush),
    .rs1_busy     (rs1_busy),
    .rs2_busy     (rs2_busy),
    .rd_busy      (rd_busy)
  );

  // identical units, each tagged with the entry allocated at its start
  for (genvar i = 0; i < num_units; i++) begin : g_unit
    exec_unit #(
      .exec_latency (exec_latency),
      .rob_depth    (rob_depth)
    ) i_exec_unit (
      .clk      (clk),
      .reset    (reset),
      .start    (unit_start[i]),
      .tag      (alloc_tag),
      .op       (in_op),
      .a        (in_a),
      .b        (in_b),
      .flush    (flush),
      .busy     (unit_busy[i]),
      .wb_valid (wb_valid[i]),
      .wb_tag   (wb_tag[i]),
      .wb_data  (wb_data[i])
    );
  end

  completion_buffer #(
    .num_units (num_units),
    .rob_depth (rob_depth)
  ) i_completion_buffer (
    .clk          (clk),
    .reset        (reset),
    .alloc        (issue),
    .alloc_fault  (in_fault),
    .alloc_pc     (in_pc),
    .alloc_rd     (in_rd),
    .alloc_wen    (in_wen),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .rob_empty    (rob_empty),
    .wb_valid     (wb_valid),
    .wb_tag       (wb_tag),
    .wb_data      (wb_data),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_data  (commit_data),
    .exception    (exception),
    .epc          (epc),
    .flush        (flush)
  );

endmodule

/* design/completion_buffer.sv */
`timescale 1ns/1ps

module completion_buffer import ooo_issue_pkg::*; #(
  parameter int num_units = default_num_units,
  parameter int rob_depth = default_rob_depth
) (
  input  logic                        clk,
  input  logic                        reset,
  // allocation from the hazard unit
  input  logic                        alloc,
  input  logic                        alloc_fault,
  input  logic [xlen-1:0]             alloc_pc,
  input  logic [reg_addr_w-1:0]       alloc_rd,
  input  logic                        alloc_wen,
  output logic [tag_w(rob_depth)-1:0] alloc_tag,
  output logic                        rob_full,
  output logic                        rob_empty,
  // one writeback port per execution unit
  input  logic [num_units-1:0]        wb_valid,
  input  logic [tag_w(rob_depth)-1:0] wb_tag [num_units],
  input  logic [xlen-1:0]             wb_data [num_units],
  // in-order retirement
  output logic                        commit_valid,
  output logic [reg_addr_w-1:0]       commit_rd,
  output logic                        commit_wen,
  output logic [xlen-1:0]             commit_data,
  output logic                        exception,
  output logic [xlen-1:0]             epc,
  output logic                        flush
);

  localparam int tw    = tag_w(rob_depth);
  localparam int cnt_w = tw + 1;

  // pointers wrap on their own since the depth is a power of two
  logic [tw-1:0]    head_q;
  logic [tw-1:0]    tail_q;
  logic [cnt_w-1:0] count_q;
  logic [rob_depth-1:0] done_q;

  // entry payload
  logic                  fault_q [rob_depth];
  logic [xlen-1:0]       pc_q    [rob_depth];
  logic [reg_addr_w-1:0] rd_q    [rob_depth];
  logic                  wen_q   [rob_depth];
  logic [xlen-1:0]       data_q  [rob_depth];

  logic head_done;
  logic retire;

  assign alloc_tag = tail_q;
  assign rob_full  = (count_q == cnt_w'(rob_depth));
  assign rob_empty = (count_q == '0);

  // head is complete and may leave at the next edge
  assign head_done = ~rob_empty & done_q[head_q];
  assign retire    = head_done;

  assign commit_valid = head_done & ~fault_q[head_q];
  assign commit_rd    = rd_q[head_q];
  assign commit_wen   = wen_q[head_q];
  assign commit_data  = data_q[head_q];

  // a faulting head turns into the flush, no commit for it
  assign exception = head_done & fault_q[head_q];
  assign epc       = pc_q[head_q];
  assign flush     = exception;

  always_ff @(posedge clk) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else if (flush) begin
      // drop the faulting entry and everything younger
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      // several units may finish in the same cycle
      for (int u = 0; u < num_units; u++) begin
        if (wb_valid[u]) begin
          done_q[wb_tag[u]] <= 1'b1;
        end
      end
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      // faults arrive already done
      if (alloc) begin
        done_q[tail_q] <= alloc_fault;
        tail_q         <= tail_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(alloc) - cnt_w'(retire);
    end
  end

  always_ff @(posedge clk) begin
    for (int u = 0; u < num_units; u++) begin
      if (wb_valid[u]) begin
        data_q[wb_tag[u]] <= wb_data[u];
      end
    end
    if (alloc) begin
      fault_q[tail_q] <= alloc_fault;
      pc_q[tail_q]    <= alloc_pc;
      rd_q[tail_q]    <= alloc_rd;
      wen_q[tail_q]   <= alloc_wen;
    end
  end

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import ooo_issue_pkg::*; #(
  parameter int exec_latency = default_exec_latency,
  parameter int rob_depth    = default_rob_depth
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  logic [tag_w(rob_depth)-1:0] tag,
  input  alu_op_t                     op,
  input  logic [xlen-1:0]             a,
  input  logic [xlen-1:0]             b,
  input  logic                        flush,
  output logic                        busy,
  output logic                        wb_valid,
  output logic [tag_w(rob_depth)-1:0] wb_tag,
  output logic [xlen-1:0]             wb_data
);

  // counts down from latency-1 to zero
  localparam int cnt_w = (exec_latency > 1) ? $clog2(exec_latency) : 1;

  logic [cnt_w-1:0] count_q;
  alu_op_t          op_q;
  logic [xlen-1:0]  a_q;
  logic [xlen-1:0]  b_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      wb_valid <= 1'b0;
      count_q  <= '0;
    end else if (flush) begin
      // abort without writing back
      busy     <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      // writeback is a single-cycle pulse
      wb_valid <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        count_q <= cnt_w'(exec_latency - 1);
      end else if (busy) begin
        if (count_q == '0) begin
          busy     <= 1'b0;
          wb_valid <= 1'b1;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // operand latches and result, loaded at start and at expiry
  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= op;
      a_q    <= a;
      b_q    <= b;
      wb_tag <= tag;
    end
    if (busy && count_q == '0) begin
      wb_data <= alu_result(op_q, a_q, b_q);
    end
  end

endmodule

/* design/busy_scoreboard.sv */
`timescale 1ns/1ps

module busy_scoreboard import ooo_issue_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue,
  input  logic [reg_addr_w-1:0] in_rd,
  input  logic                  in_wen,
  input  logic [reg_addr_w-1:0] in_rs1,
  input  logic [reg_addr_w-1:0] in_rs2,
  input  logic                  commit_valid,
  input  logic [reg_addr_w-1:0] commit_rd,
  input  logic                  commit_wen,
  input  logic                  flush,
  output logic                  rs1_busy,
  output logic                  rs2_busy,
  output logic                  rd_busy
);

  localparam int num_regs = 2 ** reg_addr_w;

  // one pending-write bit per register, x0 has none
  logic [num_regs-1:1] busy_q;

  logic set_en;
  logic clr_en;

  // x0 writes are dropped by the register file anyway
  assign set_en = issue & in_wen & (in_rd != '0);
  assign clr_en = commit_valid & commit_wen & (commit_rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= '0;
    end else if (flush) begin
      // everything in flight is discarded
      busy_q <= '0;
    end else begin
      // a busy rd stalls issue, so set and clear never hit the same register
      if (clr_en) begin
        busy_q[commit_rd] <= 1'b0;
      end
      if (set_en) begin
        busy_q[in_rd] <= 1'b1;
      end
    end
  end

  // combinational lookups for the held instruction
  assign rs1_busy = (in_rs1 != '0) ? busy_q[in_rs1] : 1'b0;
  assign rs2_busy = (in_rs2 != '0) ? busy_q[in_rs2] : 1'b0;
  assign rd_busy  = (in_rd  != '0) ? busy_q[in_rd]  : 1'b0;

endmodule

/* design/ooo_hazard_unit.sv */
`timescale 1ns/1ps

module ooo_hazard_unit import ooo_issue_pkg::*; #(
  parameter int num_units = default_num_units
) (
  input  logic                             in_valid,
  input  logic [unit_idx_w(num_units)-1:0] in_unit,
  input  logic                             in_use_rs1,
  input  logic                             in_use_rs2,
  input  logic                             in_wen,
  input  logic                             in_store,
  input  logic                             in_fault,
  input  logic                             rs1_busy,
  input  logic                             rs2_busy,
  input  logic                             rd_busy,
  input  logic [num_units-1:0]             unit_busy,
  input  logic                             rob_full,
  input  logic                             rob_empty,
  input  logic                             flush,
  output logic                             stall,
  output logic                             issue,
  output logic [num_units-1:0]             unit_start
);

  localparam int uw = unit_idx_w(num_units);

  logic data_hazard;
  logic structural_hazard;
  logic store_hazard;
  logic src_hazard;
  logic dst_hazard;

  // RAW, only sources the instruction actually reads
  assign src_hazard = (rs1_busy & in_use_rs1) | (rs2_busy & in_use_rs2);
  // WAW, only when the instruction writes its rd
  assign dst_hazard = rd_busy & in_wen;
  assign data_hazard = src_hazard | dst_hazard;

  // target unit still running an earlier op
  always_comb begin
    structural_hazard = 1'b0;
    for (int i = 0; i < num_units; i++) begin
      if (in_unit == uw'(i)) begin
        structural_hazard = unit_busy[i];
      end
    end
  end

  // stores serialize: wait until every older instruction has left the buffer
  assign store_hazard = in_store & ~rob_empty;

  // a fault never occupies a unit, so a busy unit does not hold it back
  assign stall = in_valid & (data_hazard
                           | (structural_hazard & ~in_fault)
                           | rob_full
                           | store_hazard
                           | flush);

  assign issue = in_valid & ~stall;

  // one-hot start, faults are allocated already complete
  always_comb begin
    unit_start = '0;
    for (int i = 0; i < num_units; i++) begin
      if (in_unit == uw'(i)) begin
        unit_start[i] = issue & ~in_fault;
      end
    end
  end

endmodule

/* design/ooo_issue_pkg.sv */
package ooo_issue_pkg;

  // operand and result width
  localparam int xlen = 32;
  // register index width, x0 is hardwired zero
  localparam int reg_addr_w = 5;

  // defaults for the top level parameters
  localparam int default_num_units    = 3;
  localparam int default_rob_depth    = 8;
  localparam int default_exec_latency = 3;

  // operation performed by an execution unit
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_xor = 2'd2,
    op_sll = 2'd3
  } alu_op_t;

  // unit index width, at least one bit even for a single unit
  function automatic int unit_idx_w(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // completion buffer tag width
  function automatic int tag_w(int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // result of one operation, sll shifts by the low five bits of b
  function automatic logic [xlen-1:0] alu_result(alu_op_t op, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_xor:  return a ^ b;
      default: return a << b[4:0];
    endcase
  endfunction

endpackage
